// ==== flist.f ====
+incdir+hw
hw/memTypesPkg.sv
hw/ctrlTypesPkg.sv
hw/byteRam.sv
hw/memCtrl.sv
hw/instFetch.sv
hw/loadStore.sv
hw/memSubsys.sv
testbench/memSubsys_assert.sv
testbench/memSubsysTb.sv

// ==== hw/byteRam.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module byteRam (
    input  logic              clk,
    input  logic              we,
    input  memTypesPkg::addrT addr,
    input  memTypesPkg::byteT wdata,
    output memTypesPkg::byteT rdata
);
    localparam int Depth = 1 << `MEM_DEPTH_LOG;

    memTypesPkg::byteT mem [Depth] = '{default: '0};

    logic [`MEM_DEPTH_LOG-1:0] index;

    // wraps within the array
    assign index = addr[`MEM_DEPTH_LOG-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        // old data on a same-cycle write
        rdata <= mem[index];
    end

endmodule

// ==== hw/ctrlTypesPkg.sv ====
package ctrlTypesPkg;

    // memory controller sequencing
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } ctrlStateT;

    // which requester holds the RAM
    typedef enum logic [1:0] {
        NONE,
        FETCH,
        DATA
    } ownerT;

    // fetcher request state
    typedef enum logic {
        REQ,
        WAIT
    } fetchStateT;

endpackage

// ==== hw/instFetch.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module instFetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              jumpEn,
    input  memTypesPkg::addrT jumpPc,
    input  logic              instReady,
    output logic              instValid,
    output memTypesPkg::wordT inst,
    output memTypesPkg::addrT instPc,
    output logic              fetchEn,
    output memTypesPkg::addrT fetchAddr,
    input  logic              fetchDone,
    input  memTypesPkg::wordT fetchInst
);
    ctrlTypesPkg::fetchStateT state;

    memTypesPkg::addrT pc;
    memTypesPkg::addrT reqAddr;

    // result of the fetch in flight is stale
    logic discard;
    // enable stays low for a cycle after done
    logic holdOff;
    logic issue;

    assign issue = (state == ctrlTypesPkg::REQ) && !holdOff && !jumpEn
                && (!instValid || instReady);

    assign fetchEn   = issue || (state == ctrlTypesPkg::WAIT);
    assign fetchAddr = (state == ctrlTypesPkg::WAIT) ? reqAddr : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ctrlTypesPkg::REQ;
            pc        <= memTypesPkg::addrT'(`RESET_PC);
            instValid <= 1'b0;
            discard   <= 1'b0;
            holdOff   <= 1'b0;
        end else begin
            holdOff <= fetchDone;
            if (instValid && instReady) begin
                instValid <= 1'b0;
            end
            case (state)
                ctrlTypesPkg::REQ: begin
                    if (issue) begin
                        state   <= ctrlTypesPkg::WAIT;
                        reqAddr <= pc;
                        pc      <= pc + memTypesPkg::addrT'(`PC_STEP);
                    end
                end
                ctrlTypesPkg::WAIT: begin
                    if (fetchDone) begin
                        state   <= ctrlTypesPkg::REQ;
                        discard <= 1'b0;
                        if (!discard && !jumpEn) begin
                            instValid <= 1'b1;
                            inst      <= fetchInst;
                            instPc    <= reqAddr;
                        end
                    end else if (jumpEn) begin
                        discard <= 1'b1;
                    end
                end
                default: begin
                    state <= ctrlTypesPkg::REQ;
                end
            endcase
            // redirect overrides the buffer and the next fetch address
            if (jumpEn) begin
                instValid <= 1'b0;
                pc        <= jumpPc;
            end
        end
    end

endmodule

// ==== hw/loadStore.sv ====
`timescale 1ns/1ps

module loadStore (
    input  logic              clk,
    input  logic              rst,
    input  logic              lsuReq,
    input  logic              lsuStore,
    input  logic              lsuSigned,
    input  memTypesPkg::lenT  lsuLen,
    input  memTypesPkg::addrT lsuAddr,
    input  memTypesPkg::wordT lsuWdata,
    output logic              lsuDone,
    output memTypesPkg::wordT lsuRdata,
    output logic              dataEn,
    output logic              dataStore,
    output memTypesPkg::lenT  dataLen,
    output memTypesPkg::addrT dataAddr,
    output memTypesPkg::wordT dataWdata,
    input  logic              dataDone,
    input  memTypesPkg::wordT dataRdata
);
    logic              signedQ;
    memTypesPkg::wordT extended;

    // controller returns loads zero-extended
    always_comb begin
        case (dataLen)
            3'd1: begin
                extended = {{24{signedQ & dataRdata[7]}}, dataRdata[7:0]};
            end
            3'd2: begin
                extended = {{16{signedQ & dataRdata[15]}}, dataRdata[15:0]};
            end
            default: begin
                extended = dataRdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dataEn  <= 1'b0;
            lsuDone <= 1'b0;
        end else begin
            lsuDone <= 1'b0;
            if (dataEn) begin
                if (dataDone) begin
                    dataEn   <= 1'b0;
                    lsuDone  <= 1'b1;
                    lsuRdata <= dataStore ? '0 : extended;
                end
            end else if (lsuReq && !lsuDone) begin
                // lsuReq is still the old request while lsuDone is high
                dataEn    <= 1'b1;
                dataStore <= lsuStore;
                dataLen   <= lsuLen;
                dataAddr  <= lsuAddr;
                dataWdata <= lsuWdata;
                signedQ   <= lsuSigned;
            end
        end
    end

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioFull,
    // fetch link
    input  logic              fetchEn,
    input  memTypesPkg::addrT fetchAddr,
    output logic              fetchDone,
    output memTypesPkg::wordT fetchInst,
    // data link
    input  logic              dataEn,
    input  logic              dataStore,
    input  memTypesPkg::lenT  dataLen,
    input  memTypesPkg::addrT dataAddr,
    input  memTypesPkg::wordT dataWdata,
    output logic              dataDone,
    output memTypesPkg::wordT dataRdata,
    // byte RAM
    output memTypesPkg::addrT ramAddr,
    output logic              ramWe,
    output memTypesPkg::byteT ramWdata,
    input  memTypesPkg::byteT ramRdata
);
    ctrlTypesPkg::ctrlStateT state;
    ctrlTypesPkg::ownerT     ownerReg;
    ctrlTypesPkg::ownerT     owner;

    // next byte index to issue
    memTypesPkg::lenT  idx;
    memTypesPkg::wordT assembled;
    memTypesPkg::addrT lastAddr;

    logic              pause;
    logic              curStore;
    logic              issuing;
    logic [1:0]        rxPos;
    memTypesPkg::lenT  curIdx;
    memTypesPkg::lenT  curLen;
    memTypesPkg::addrT curBase;
    memTypesPkg::addrT issueAddr;
    memTypesPkg::wordT merged;

    assign pause = !rdy || ioFull;

    // data wins, but only from idle
    always_comb begin
        if (state == ctrlTypesPkg::IDLE) begin
            if (dataEn) begin
                owner = ctrlTypesPkg::DATA;
            end else if (fetchEn) begin
                owner = ctrlTypesPkg::FETCH;
            end else begin
                owner = ctrlTypesPkg::NONE;
            end
        end else begin
            owner = ownerReg;
        end
    end

    assign curBase  = (owner == ctrlTypesPkg::DATA) ? dataAddr : fetchAddr;
    assign curLen   = (owner == ctrlTypesPkg::DATA) ? dataLen : memTypesPkg::lenT'(`PC_STEP);
    assign curStore = (owner == ctrlTypesPkg::DATA) && dataStore;
    assign curIdx   = (state == ctrlTypesPkg::IDLE) ? '0 : idx;

    assign issuing = ((state == ctrlTypesPkg::IDLE) && (owner != ctrlTypesPkg::NONE))
                  || ((state == ctrlTypesPkg::BUSY) && (idx < curLen));

    assign issueAddr = curBase + memTypesPkg::addrT'(curIdx);

    // a paused cycle re-reads the last issued byte so it is still there afterwards
    assign ramAddr  = pause ? lastAddr : issueAddr;
    assign ramWe    = !pause && issuing && curStore;
    assign ramWdata = dataWdata[{curIdx[1:0], 3'b000} +: 8];

    // byte arriving now was issued at idx - 1
    assign rxPos = idx[1:0] - 2'd1;

    always_comb begin
        merged = assembled;
        merged[{rxPos, 3'b000} +: 8] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ctrlTypesPkg::IDLE;
            ownerReg  <= ctrlTypesPkg::NONE;
            idx       <= '0;
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
            if (!pause) begin
                lastAddr <= issueAddr;
                case (state)
                    ctrlTypesPkg::IDLE: begin
                        if (owner != ctrlTypesPkg::NONE) begin
                            ownerReg  <= owner;
                            idx       <= 3'd1;
                            // cleared so short loads come out zero-extended
                            assembled <= '0;
                            if (curStore && (curLen == 3'd1)) begin
                                state    <= ctrlTypesPkg::DONE;
                                dataDone <= 1'b1;
                            end else begin
                                state <= ctrlTypesPkg::BUSY;
                            end
                        end
                    end
                    ctrlTypesPkg::BUSY: begin
                        if (curStore) begin
                            if (idx == curLen - 3'd1) begin
                                state    <= ctrlTypesPkg::DONE;
                                dataDone <= 1'b1;
                            end else begin
                                idx <= idx + 3'd1;
                            end
                        end else if (idx == curLen) begin
                            state <= ctrlTypesPkg::DONE;
                            if (owner == ctrlTypesPkg::FETCH) begin
                                fetchDone <= 1'b1;
                                fetchInst <= merged;
                            end else begin
                                dataDone  <= 1'b1;
                                dataRdata <= merged;
                            end
                        end else begin
                            assembled <= merged;
                            idx       <= idx + 3'd1;
                        end
                    end
                    ctrlTypesPkg::DONE: begin
                        // requester still holds its enable this cycle
                        state    <= ctrlTypesPkg::IDLE;
                        ownerReg <= ctrlTypesPkg::NONE;
                    end
                    default: begin
                        state <= ctrlTypesPkg::IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioFull,
    // fetch side
    input  logic              jumpEn,
    input  memTypesPkg::addrT jumpPc,
    output logic              instValid,
    output memTypesPkg::wordT inst,
    output memTypesPkg::addrT instPc,
    input  logic              instReady,
    // data side
    input  logic              lsuReq,
    input  logic              lsuStore,
    input  logic              lsuSigned,
    input  memTypesPkg::lenT  lsuLen,
    input  memTypesPkg::addrT lsuAddr,
    input  memTypesPkg::wordT lsuWdata,
    output logic              lsuDone,
    output memTypesPkg::wordT lsuRdata
);
    logic              fetchEn;
    logic              fetchDone;
    memTypesPkg::addrT fetchAddr;
    memTypesPkg::wordT fetchInst;

    logic              dataEn;
    logic              dataStore;
    logic              dataDone;
    memTypesPkg::lenT  dataLen;
    memTypesPkg::addrT dataAddr;
    memTypesPkg::wordT dataWdata;
    memTypesPkg::wordT dataRdata;

    logic              ramWe;
    memTypesPkg::addrT ramAddr;
    memTypesPkg::byteT ramWdata;
    memTypesPkg::byteT ramRdata;

    instFetch uFetch (
        .clk       (clk),
        .rst       (rst),
        .jumpEn    (jumpEn),
        .jumpPc    (jumpPc),
        .instReady (instReady),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    loadStore uLsu (
        .clk       (clk),
        .rst       (rst),
        .lsuReq    (lsuReq),
        .lsuStore  (lsuStore),
        .lsuSigned (lsuSigned),
        .lsuLen    (lsuLen),
        .lsuAddr   (lsuAddr),
        .lsuWdata  (lsuWdata),
        .lsuDone   (lsuDone),
        .lsuRdata  (lsuRdata),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

    memCtrl uCtrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    byteRam uRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// ==== hw/memTypesPkg.sv ====
package memTypesPkg;

    // byte address as seen by both requesters
    typedef logic [31:0] addrT;

    // one RAM location
    typedef logic [7:0] byteT;

    // instruction or load/store data word
    typedef logic [31:0] wordT;

    // access length in bytes, 1, 2 or 4
    typedef logic [2:0] lenT;

endpackage

// ==== hw/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// log2 of the RAM size in bytes, upper address bits are ignored
`define MEM_DEPTH_LOG 12

// first instruction address after reset
`define RESET_PC 32'h0000_0000

// bytes per instruction, also the length of a fetch
`define PC_STEP 4

`endif

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -f flist.f --top-module memSubsysTb -Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log
if grep -q "All tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/memSubsysTb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module memSubsysTb;
    localparam int Depth = 1 << `MEM_DEPTH_LOG;
    localparam int MaxCycles = 4000;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    logic              rdy = 1'b1;
    logic              ioFull = 1'b0;
    logic              jumpEn = 1'b0;
    memTypesPkg::addrT jumpPc = '0;
    logic              instReady = 1'b0;
    logic              instValid;
    memTypesPkg::wordT inst;
    memTypesPkg::addrT instPc;
    logic              lsuReq = 1'b0;
    logic              lsuStore = 1'b0;
    logic              lsuSigned = 1'b0;
    memTypesPkg::lenT  lsuLen = 3'd4;
    memTypesPkg::addrT lsuAddr = '0;
    memTypesPkg::wordT lsuWdata = '0;
    logic              lsuDone;
    memTypesPkg::wordT lsuRdata;

    // reference copy of the RAM contents
    memTypesPkg::byteT shadow [Depth] = '{default: '0};

    int                valueErrors = 0;
    int                protocolErrors = 0;
    int                cycles = 0;
    logic [1:0]        pauseHist = '0;
    logic              prevHold = 1'b0;
    memTypesPkg::wordT prevInst;
    memTypesPkg::addrT prevPc;

    memSubsys DUT (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MaxCycles) begin
            $display("timeout: the DUT did not finish within %0d cycles", MaxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // lsuDone needs an unpaused cycle two cycles earlier
    always @(negedge clk) begin
        if (!rst) begin
            if (lsuDone && pauseHist[1]) begin
                $display("lsuDone raised at %0t although the controller was paused", $time);
                protocolErrors++;
            end
            if (prevHold && (!instValid || inst !== prevInst || instPc !== prevPc)) begin
                $display("inst or instPc changed at %0t while instReady was low", $time);
                protocolErrors++;
            end
        end
        pauseHist = {pauseHist[0], !rdy || ioFull};
        prevHold = instValid && !instReady && !jumpEn;
        prevInst = inst;
        prevPc = instPc;
    end

    function automatic logic [`MEM_DEPTH_LOG-1:0] slot(memTypesPkg::addrT addr);
        return addr[`MEM_DEPTH_LOG-1:0];
    endfunction

    function automatic void recordStore(memTypesPkg::addrT addr, memTypesPkg::lenT len,
            memTypesPkg::wordT data);
        for (int i = 0; i < len; i++) begin
            shadow[slot(addr + i)] = data[8*i +: 8];
        end
    endfunction

    // little endian, then sign or zero extension from bit 8*len-1
    function automatic memTypesPkg::wordT expectedLoad(memTypesPkg::addrT addr,
            memTypesPkg::lenT len, logic sgn);
        memTypesPkg::wordT w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[8*i +: 8] = shadow[slot(addr + i)];
        end
        if (sgn && len < 3'd4) begin
            w = w | ({32{w[8*len-1]}} << (8*len));
        end
        return w;
    endfunction

    task automatic checkWord(input string what, input memTypesPkg::wordT got,
            input memTypesPkg::wordT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(input string what, input memTypesPkg::addrT got,
            input memTypesPkg::addrT exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic lsuAccess(input logic store, input logic sgn, input memTypesPkg::lenT len,
            input memTypesPkg::addrT addr, input memTypesPkg::wordT wdata, input logic stall);
        memTypesPkg::wordT got;
        logic seen;
        seen = 1'b0;
        @(posedge clk);
        lsuReq    <= 1'b1;
        lsuStore  <= store;
        lsuSigned <= sgn;
        lsuLen    <= len;
        lsuAddr   <= addr;
        lsuWdata  <= wdata;
        while (!seen) begin
            @(negedge clk);
            seen = lsuDone;
            got = lsuRdata;
            @(posedge clk);
            if (stall) begin
                rdy    <= ($urandom % 3) != 0;
                ioFull <= ($urandom % 4) == 0;
            end
        end
        lsuReq <= 1'b0;
        rdy    <= 1'b1;
        ioFull <= 1'b0;
        if (store) begin
            recordStore(addr, len, wdata);
        end
        checkWord($sformatf("%s len %0d at %h", store ? "store" : "load", len, addr), got,
                  store ? '0 : expectedLoad(addr, len, sgn));
    endtask

    task automatic waitInst(input memTypesPkg::addrT pc);
        do begin
            @(negedge clk);
        end while (!instValid);
        checkAddr("instPc", instPc, pc);
        checkWord($sformatf("inst at %h", pc), inst, expectedLoad(pc, 3'd4, 1'b0));
        @(posedge clk);
        instReady <= 1'b1;
        @(posedge clk);
        instReady <= 1'b0;
    endtask

    task automatic jump(input memTypesPkg::addrT target);
        @(posedge clk);
        jumpEn <= 1'b1;
        jumpPc <= target;
        @(posedge clk);
        jumpEn <= 1'b0;
    endtask

    initial begin
        memTypesPkg::addrT addrs [8];
        memTypesPkg::addrT base;
        memTypesPkg::addrT addr;
        void'($urandom(96));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // word round trip
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 32'h800 | ($urandom & 32'h7fc);
            lsuAccess(1'b1, 1'b0, 3'd4, addrs[i], $urandom, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            lsuAccess(1'b0, 1'b0, 3'd4, addrs[i], 0, 1'b0);
        end

        // byte and halfword loads, signed and unsigned
        lsuAccess(1'b1, 1'b0, 3'd4, 32'h700, 32'h80f1_7f92, 1'b0);
        lsuAccess(1'b1, 1'b0, 3'd1, 32'h704, 32'h0000_00c3, 1'b0);
        lsuAccess(1'b1, 1'b0, 3'd2, 32'h706, 32'h0000_8001, 1'b0);
        for (int i = 0; i < 16; i++) begin
            lsuAccess(1'b0, i[0], 3'd1, 32'h700 + (i >> 1), 0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            lsuAccess(1'b0, i[0], 3'd2, 32'h700 + 2 * (i >> 1), 0, 1'b0);
        end

        // fetch stream after a redirect
        base = 32'h100;
        for (int k = 0; k < 4; k++) begin
            lsuAccess(1'b1, 1'b0, 3'd4, base + 4 * k, $urandom, 1'b0);
        end
        jump(base);
        for (int k = 0; k < 4; k++) begin
            waitInst(base + 4 * k);
        end

        // loads racing the fetcher
        base = 32'h200;
        for (int k = 0; k < 8; k++) begin
            lsuAccess(1'b1, 1'b0, 3'd4, base + 4 * k, $urandom, 1'b0);
        end
        jump(base);
        fork
            for (int k = 0; k < 8; k++) begin
                waitInst(base + 4 * k);
            end
            for (int k = 0; k < 6; k++) begin
                lsuAccess(1'b0, 1'b0, 3'd4, addrs[k], 0, 1'b0);
            end
        join

        // pauses, then the buffered instruction waits on instReady
        addr = 32'h900 | ($urandom & 32'h0fc);
        lsuAccess(1'b1, 1'b0, 3'd4, addr, $urandom, 1'b1);
        lsuAccess(1'b0, 1'b0, 3'd4, addr, 0, 1'b1);
        lsuAccess(1'b1, 1'b0, 3'd2, addr + 2, $urandom, 1'b1);
        lsuAccess(1'b0, 1'b1, 3'd2, addr + 2, 0, 1'b1);
        repeat (12) @(posedge clk);
        waitInst(base + 32);
        waitInst(base + 36);

        $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/memSubsys_assert.sv ====
`timescale 1ns/1ps

module memSubsysAssert (
    input logic                    clk,
    input logic                    rst,
    input logic                    rdy,
    input logic                    ioFull,
    input logic                    ramWe,
    input logic                    fetchDone,
    input logic                    dataDone,
    input ctrlTypesPkg::ownerT     owner,
    input ctrlTypesPkg::ctrlStateT state,
    input memTypesPkg::lenT        idx
);
    // done is a single-cycle pulse on either link
    doneSingle: assert property (@(posedge clk) disable iff (rst)
        (fetchDone || dataDone) |=> !(fetchDone || dataDone))
        else $error("done held high for two cycles");

    // a paused cycle writes nothing and leaves the sequencer where it was
    noWriteWhilePaused: assert property (@(posedge clk) disable iff (rst)
        (!rdy || ioFull) |=> !$past(ramWe) && $stable(state) && $stable(idx))
        else $error("RAM write or controller progress while the controller is paused");

    // the latched grant behind every written byte is the data link
    writeOnlyForData: assert property (@(posedge clk) disable iff (rst)
        ramWe |=> (owner == ctrlTypesPkg::DATA))
        else $error("RAM write while the data link does not own the bus");

endmodule

bind memCtrl memSubsysAssert uAssert (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .ioFull    (ioFull),
    .ramWe     (ramWe),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .owner     (ownerReg),
    .state     (state),
    .idx       (idx)
);
